/* src/cdc_settings.svh */
// stream cdc settings
// sample, tag and fifo geometry shared by the whole subsystem
`ifndef CDC_SETTINGS_SVH
`define CDC_SETTINGS_SVH

// width of one input sample
`define CDC_SAMPLE_W    16

// sequence tag width, wraps at 64
`define CDC_SEQ_W       6

// fifo entries, must be a power of two
`define CDC_FIFO_DEPTH  16

// flops per bit on every clock crossing
`define CDC_SYNC_STAGES 2

`endif

/* src/cdc_pkg.sv */
// stream cdc types
// vector typedefs, fifo payload struct and consumer fsm states
`include "cdc_settings.svh"

package cdc_pkg;

   //##########################################################################
   // plain vectors
   //##########################################################################

   typedef logic [`CDC_SAMPLE_W-1:0] sample_t;    // one sample
   typedef logic [`CDC_SEQ_W-1:0]    seq_t;       // sequence tag, wraps

   // fifo pointer, address plus one wrap bit
   typedef logic [$clog2(`CDC_FIFO_DEPTH):0]   ptr_t;
   typedef logic [$clog2(`CDC_FIFO_DEPTH)-1:0] addr_t;    // ram address

   typedef logic [15:0] drop_cnt_t;               // saturating drop counter

   //##########################################################################
   // fifo payload
   //##########################################################################

   typedef struct packed {
      seq_t    tag;                               // upper bits
      sample_t data;
   } fifo_word_t;

   // read side consumer
   typedef enum logic [1:0] {
      IDLE,                                       // wait for data
      FETCH,                                      // fifo_rd high
      PRESENT                                     // ram output valid
   } unpack_state_t;

endpackage

/* src/rst_sync.sv */
// reset synchronizer
// asserts low at once, releases after a short chain of clean clock edges
`timescale 1ns/1ns
`include "cdc_settings.svh"

module rst_sync (
   input  logic clk,
   input  logic nreset_in,                        // raw async reset
   output logic nreset_out                        // release synced to clk
);

   localparam int STAGES = `CDC_SYNC_STAGES;

   logic [STAGES-1:0] sync_q;                     // shift chain of ones

   always_ff @(posedge clk or negedge nreset_in) begin
      if (!nreset_in) begin
         sync_q <= '0;                            // assert asynchronously
      end else begin
         sync_q <= {sync_q[STAGES-2:0], 1'b1};    // shift in release
      end
   end

   // last stage drives the domain reset
   assign nreset_out = sync_q[STAGES-1];

endmodule

/* src/gray_sync.sv */
// gray pointer crossing
// source side registers the gray code, destination side runs it through
// a flop chain and turns it back into a binary pointer
`timescale 1ns/1ns
`include "cdc_settings.svh"

module gray_sync
   import cdc_pkg::*;
(
   input  logic src_clk,
   input  logic src_rst_n,
   input  ptr_t src_ptr,                          // binary, source domain
   input  logic dst_clk,
   input  logic dst_rst_n,
   output ptr_t dst_ptr                           // binary, destination domain
);

   localparam int PW     = $bits(ptr_t);
   localparam int STAGES = `CDC_SYNC_STAGES;

   ptr_t              src_gray;                   // only one bit moves per step
   ptr_t [STAGES-1:0] sync_q;                     // stage 0 is the meta flop

   //##########################################################################
   // source domain
   //##########################################################################

   always_ff @(posedge src_clk or negedge src_rst_n) begin
      if (!src_rst_n) begin
         src_gray <= '0;
      end else begin
         src_gray <= src_ptr ^ (src_ptr >> 1);    // bin to gray
      end
   end

   //##########################################################################
   // destination domain
   //##########################################################################

   always_ff @(posedge dst_clk or negedge dst_rst_n) begin
      if (!dst_rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[STAGES-2:0], src_gray};
      end
   end

   // gray to bin, each bit is the xor of all gray bits above and at it
   always_comb begin
      for (int i = 0; i < PW; i++) begin
         dst_ptr[i] = ^(sync_q[STAGES-1] >> i);
      end
   end

endmodule

/* src/dual_port_ram.sv */
// two clock memory
// write port on wr_clk, registered read port on rd_clk
`timescale 1ns/1ns
`include "cdc_settings.svh"

module dual_port_ram
   import cdc_pkg::*;
(
   // write port
   input  logic       wr_clk,
   input  logic       wr_en,
   input  addr_t      wr_addr,
   input  fifo_word_t wr_data,
   // read port
   input  logic       rd_clk,
   input  logic       rd_en,                      // load output register
   input  addr_t      rd_addr,
   output fifo_word_t rd_data                     // valid the cycle after rd_en
);

   fifo_word_t mem [`CDC_FIFO_DEPTH];             // storage array

   // write side
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // read side
   // output register holds its word between reads
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

/* src/async_fifo.sv */
// asynchronous fifo
// binary pointers with a wrap bit, gray coded crossings into the other
// domain, full and empty from the synced pointers, dual port storage
`timescale 1ns/1ns

module async_fifo
   import cdc_pkg::*;
(
   // write domain
   input  logic       wr_clk,
   input  logic       wr_rst_n,
   input  logic       fifo_wr,                    // one write per high cycle
   input  fifo_word_t wr_word,
   output logic       wr_full,
   // read domain
   input  logic       rd_clk,
   input  logic       rd_rst_n,
   input  logic       fifo_rd,                    // one read per high cycle
   output logic       rd_empty,
   output fifo_word_t rd_word                     // one cycle after fifo_rd
);

   localparam int AW = $bits(addr_t);             // wrap bit sits at AW

   ptr_t wr_ptr;
   ptr_t wr_ptr_next;                             // pointer after pending write
   ptr_t rd_ptr;
   ptr_t wr_ptr_sync;                             // write pointer in rd domain
   ptr_t rd_ptr_sync;                             // read pointer in wr domain

   //##########################################################################
   // write pointer
   //##########################################################################

   assign wr_ptr_next = wr_ptr + ptr_t'(fifo_wr);

   always_ff @(posedge wr_clk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         wr_ptr <= '0;
      end else begin
         wr_ptr <= wr_ptr_next;
      end
   end

   //##########################################################################
   // read pointer
   //##########################################################################

   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         rd_ptr <= '0;
      end else if (fifo_rd) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   //##########################################################################
   // pointer crossings
   //##########################################################################

   gray_sync i_wr2rd_sync (
      .src_clk   (wr_clk),
      .src_rst_n (wr_rst_n),
      .src_ptr   (wr_ptr),
      .dst_clk   (rd_clk),
      .dst_rst_n (rd_rst_n),
      .dst_ptr   (wr_ptr_sync)
   );

   gray_sync i_rd2wr_sync (
      .src_clk   (rd_clk),
      .src_rst_n (rd_rst_n),
      .src_ptr   (rd_ptr),
      .dst_clk   (wr_clk),
      .dst_rst_n (wr_rst_n),
      .dst_ptr   (rd_ptr_sync)
   );

   //##########################################################################
   // flags
   //##########################################################################

   // full counts the write already in flight
   // stale read pointer keeps it pessimistic
   assign wr_full  = (wr_ptr_next[AW-1:0] == rd_ptr_sync[AW-1:0]) &&
                     (wr_ptr_next[AW]     != rd_ptr_sync[AW]);

   assign rd_empty = (rd_ptr == wr_ptr_sync);     // stale write pointer

   //##########################################################################
   // storage
   //##########################################################################

   dual_port_ram i_dual_port_ram (
      .wr_clk  (wr_clk),
      .wr_en   (fifo_wr),
      .wr_addr (wr_ptr[AW-1:0]),
      .wr_data (wr_word),
      .rd_clk  (rd_clk),
      .rd_en   (fifo_rd),
      .rd_addr (rd_ptr[AW-1:0]),
      .rd_data (rd_word)
   );

endmodule

/* src/sample_framer.sv */
// sample framer for the write side
// tags every accepted sample with a wrapping sequence number and writes
// it to the fifo one cycle later, drops and counts samples met by full
`timescale 1ns/1ns

module sample_framer
   import cdc_pkg::*;
(
   input  logic       wr_clk,
   input  logic       wr_rst_n,
   input  logic       in_valid,                   // plain input strobe
   input  sample_t    in_sample,
   input  logic       wr_full,
   output logic       fifo_wr,                    // registered write strobe
   output fifo_word_t wr_word,                    // registered payload
   output drop_cnt_t  drop_count                  // saturates at all ones
);

   seq_t next_tag;                                // tag for the next accept
   logic accept;
   logic drop;                                    // sample met a full fifo
   logic drop_q;                                  // counted one edge later

   assign accept = in_valid & ~wr_full;
   assign drop   = in_valid & wr_full;

   //##########################################################################
   // control
   //##########################################################################

   always_ff @(posedge wr_clk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         fifo_wr    <= 1'b0;
         drop_q     <= 1'b0;
         next_tag   <= '0;
         drop_count <= '0;
      end else begin
         fifo_wr <= accept;
         drop_q  <= drop;
         if (accept) begin
            next_tag <= next_tag + 1'b1;          // wraps at 64
         end
         // lost sample counted where its write would have landed
         if (drop_q && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
         end
      end
   end

   // payload
   always_ff @(posedge wr_clk) begin
      if (accept) begin
         wr_word <= '{tag: next_tag, data: in_sample};
      end
   end

endmodule

/* src/stream_unpacker.sv */
// stream unpacker, read side consumer
// pops one word at a time, presents it as a one cycle strobe and flags
// any tag that does not follow the previous one
`timescale 1ns/1ns

module stream_unpacker
   import cdc_pkg::*;
(
   input  logic       rd_clk,
   input  logic       rd_rst_n,
   input  logic       rd_empty,
   input  fifo_word_t rd_word,                    // valid in PRESENT
   output logic       fifo_rd,
   output logic       out_valid,                  // one cycle per word
   output fifo_word_t out_word,                   // last presented word
   output logic       seq_error                   // pulses with out_valid
);

   unpack_state_t state;
   logic          exp_set;                        // first word seen
   seq_t          exp_tag;                        // tag the next word should carry

   assign fifo_rd = (state == FETCH);             // decided on rd_empty last cycle
   assign exp_tag = out_word.tag + 1'b1;          // modulo 64

   //##########################################################################
   // fsm and output strobes
   //##########################################################################

   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         state     <= IDLE;
         out_valid <= 1'b0;
         seq_error <= 1'b0;
         exp_set   <= 1'b0;
      end else begin
         out_valid <= 1'b0;                       // default, single pulse
         seq_error <= 1'b0;
         case (state)
            IDLE: begin
               if (!rd_empty) begin
                  state <= FETCH;
               end
            end
            FETCH: state <= PRESENT;              // ram loads at this edge
            PRESENT: begin
               out_valid <= 1'b1;
               seq_error <= exp_set && (rd_word.tag != exp_tag);
               exp_set   <= 1'b1;
               state     <= rd_empty ? IDLE : FETCH;   // next pop, if any
            end
            default: state <= IDLE;
         endcase
      end
   end

   // output word, held until the next one
   always_ff @(posedge rd_clk) begin
      if (state == PRESENT) begin
         out_word <= rd_word;
      end
   end

endmodule

/* src/stream_cdc_top.sv */
// stream cdc top level
// samples cross from wr_clk into rd_clk through an async fifo
// one external reset, synchronized into each domain
`timescale 1ns/1ns

module stream_cdc_top
   import cdc_pkg::*;
(
   input  logic       wr_clk,
   input  logic       rd_clk,
   input  logic       rd_nreset,                  // async, active low
   input  logic       in_valid,
   input  sample_t    in_sample,
   output drop_cnt_t  drop_count,                 // wr_clk domain
   output logic       out_valid,                  // rd_clk domain from here
   output fifo_word_t out_word,
   output logic       seq_error
);

   logic       wr_rst_n;
   logic       rd_rst_n;
   logic       fifo_wr;
   fifo_word_t wr_word;
   logic       wr_full;
   logic       fifo_rd;
   logic       rd_empty;
   fifo_word_t rd_word;

   //##########################################################################
   // reset per domain
   //##########################################################################

   rst_sync i_wr_rst_sync (.clk(wr_clk), .nreset_in(rd_nreset), .nreset_out(wr_rst_n));
   rst_sync i_rd_rst_sync (.clk(rd_clk), .nreset_in(rd_nreset), .nreset_out(rd_rst_n));

   //##########################################################################
   // datapath
   //##########################################################################

   sample_framer i_sample_framer (
      .wr_clk     (wr_clk),
      .wr_rst_n   (wr_rst_n),
      .in_valid   (in_valid),
      .in_sample  (in_sample),
      .wr_full    (wr_full),
      .fifo_wr    (fifo_wr),
      .wr_word    (wr_word),
      .drop_count (drop_count)
   );

   async_fifo i_async_fifo (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .fifo_wr  (fifo_wr),
      .wr_word  (wr_word),
      .wr_full  (wr_full),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .fifo_rd  (fifo_rd),
      .rd_empty (rd_empty),
      .rd_word  (rd_word)
   );

   stream_unpacker i_stream_unpacker (
      .rd_clk    (rd_clk),
      .rd_rst_n  (rd_rst_n),
      .rd_empty  (rd_empty),
      .rd_word   (rd_word),
      .fifo_rd   (fifo_rd),
      .out_valid (out_valid),
      .out_word  (out_word),
      .seq_error (seq_error)
   );

endmodule

/* testbench/stream_checker.sv */
// stream checker
// watches the top level ports, logs every driven sample in order and
// compares each output word, its tag and the drop count against them
`timescale 1ns/1ns
`include "cdc_settings.svh"

module stream_checker
   import cdc_pkg::*;
(
   input  logic       wr_clk,
   input  logic       rd_clk,
   input  logic       rd_nreset,
   input  logic       burst_phase,                // drops allowed from here on
   input  logic       end_of_run,                 // request for closing checks
   input  logic       in_valid,
   input  sample_t    in_sample,
   input  drop_cnt_t  drop_count,
   input  logic       out_valid,
   input  fifo_word_t out_word,
   input  logic       seq_error,
   output logic       balanced,                   // every driven sample accounted for
   output logic       checks_done,
   output int         value_errors,
   output int         other_errors
);

   typedef struct packed {
      logic    burst;                             // driven in burst phase
      sample_t data;
   } log_entry_t;

   log_entry_t pending_q[$];                      // filled on wr_clk only
   int         driven_cnt;
   int         wr_errors;
   int         rd_errors;
   int         out_cnt;
   int         head;                              // oldest unmatched entry
   logic       have_tag;
   seq_t       last_tag;

   assign value_errors = wr_errors + rd_errors;
   assign balanced     = (driven_cnt > 0) && (out_cnt + int'(drop_count) == driven_cnt);

   //##########################################################################
   // reference functions
   //##########################################################################

   // tag that must follow prev, modulo 64
   function automatic seq_t next_tag(input seq_t prev);
      return seq_t'((int'(prev) + 1) % (1 << `CDC_SEQ_W));
   endfunction

   // first pending entry at or after head with this data, -1 if none
   function automatic int find_match(input sample_t data);
      for (int i = head; i < pending_q.size(); i++) begin
         if (pending_q[i].data == data) begin
            return i;
         end
      end
      return -1;
   endfunction

   //##########################################################################
   // comparison
   //##########################################################################

   task automatic check_output();
      int idx;
      idx = find_match(out_word.data);
      out_cnt++;
      if (idx < 0) begin
         if (head < pending_q.size()) begin
            $display("Error at %0t ns: out_word.data expected %h got %h",
                     $time, pending_q[head].data, out_word.data);
            rd_errors++;
            head++;                               // stay aligned with the log
         end else begin
            $display("Output word %h at %0t ns has no driven sample left to match",
                     out_word.data, $time);
            other_errors++;
         end
      end else begin
         // entries passed over were dropped at the input
         for (int i = head; i < idx; i++) begin
            if (!pending_q[i].burst) begin      // sparse samples never drop
               $display("Error at %0t ns: out_word.data expected %h got %h",
                        $time, pending_q[i].data, out_word.data);
               rd_errors++;
            end
         end
         head = idx + 1;
      end
      if (have_tag && out_word.tag !== next_tag(last_tag)) begin
         $display("Error at %0t ns: out_word.tag expected %0d got %0d",
                  $time, next_tag(last_tag), out_word.tag);
         rd_errors++;
      end
      have_tag = 1'b1;
      last_tag = out_word.tag;
   endtask

   task automatic closing_checks();
      int expected_drops;
      expected_drops = driven_cnt - out_cnt;      // never lost once accepted
      if (int'(drop_count) != expected_drops) begin
         $display("Error at %0t ns: drop_count expected %0d got %0d",
                  $time, expected_drops, drop_count);
         rd_errors++;
      end
      for (int i = head; i < pending_q.size(); i++) begin
         if (!pending_q[i].burst) begin
            $display("Sample %h from the sparse phase never reached the output",
                     pending_q[i].data);
            other_errors++;
         end
      end
      checks_done = 1'b1;
   endtask

   // input log and drop count, wr_clk side
   always @(posedge wr_clk) begin
      log_entry_t entry;
      if (rd_nreset) begin
         if (in_valid === 1'b1) begin
            entry.burst = burst_phase;
            entry.data  = in_sample;
            pending_q.push_back(entry);
            driven_cnt++;
         end
         if (!burst_phase && drop_count !== '0) begin
            $display("Error at %0t ns: drop_count expected 0 got %0d", $time, drop_count);
            wr_errors++;
         end
      end
   end

   // output side, rd_clk
   always @(posedge rd_clk) begin
      if (!rd_nreset) begin
         out_cnt     = 0;
         head        = 0;
         have_tag    = 1'b0;
         checks_done = 1'b0;
      end else begin
         if (seq_error !== 1'b0) begin            // tags are always consecutive
            $display("Error at %0t ns: seq_error expected 0 got %b", $time, seq_error);
            rd_errors++;
         end
         if (driven_cnt == 0 && out_valid !== 1'b0) begin
            $display("Error at %0t ns: out_valid expected 0 got %b", $time, out_valid);
            rd_errors++;
         end else if (out_valid === 1'b1) begin
            check_output();
         end
         if (end_of_run && !checks_done) begin
            closing_checks();
         end
      end
   end

endmodule

/* testbench/tb_stream_cdc.sv */
// stream cdc testbench
// two clocks, one reset, lfsr samples in a sparse and a burst phase
// checker instance does the comparing, watchdog bounds the run
`timescale 1ns/1ns

module tb_stream_cdc
   import cdc_pkg::*;
();

   localparam int RD_PERIOD   = 100;
   localparam int WR_PERIOD   = 70;
   localparam int SPARSE_N    = 80;               // enough to wrap the tag
   localparam int BURST_N     = 60;               // in_valid held high
   localparam int N_SAMPLES   = SPARSE_N + BURST_N;
   localparam int WATCHDOG_NS = (N_SAMPLES * 4 + 200) * RD_PERIOD;

   logic       rd_clk = 1'b0;
   logic       wr_clk = 1'b0;
   logic       rd_nreset;
   logic       in_valid;
   sample_t    in_sample;
   drop_cnt_t  drop_count;
   logic       out_valid;
   fifo_word_t out_word;
   logic       seq_error;

   logic        burst_phase;
   logic        end_of_run;
   logic        balanced;
   logic        checks_done;
   int          value_errors;
   int          other_errors;
   logic [31:0] lfsr_q;                           // random source

   always #(RD_PERIOD / 2) rd_clk = ~rd_clk;
   always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

   //##########################################################################
   // random bits
   //##########################################################################

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   task automatic draw_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         bits   = {bits[30:0], lfsr_q[0]};
      end
   endtask

   task automatic print_counts();
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
   endtask

   //##########################################################################
   // dut and checker
   //##########################################################################

   stream_cdc_top i_stream_cdc_top (
      .wr_clk     (wr_clk),
      .rd_clk     (rd_clk),
      .rd_nreset  (rd_nreset),
      .in_valid   (in_valid),
      .in_sample  (in_sample),
      .drop_count (drop_count),
      .out_valid  (out_valid),
      .out_word   (out_word),
      .seq_error  (seq_error)
   );

   stream_checker i_stream_checker (
      .wr_clk       (wr_clk),
      .rd_clk       (rd_clk),
      .rd_nreset    (rd_nreset),
      .burst_phase  (burst_phase),
      .end_of_run   (end_of_run),
      .in_valid     (in_valid),
      .in_sample    (in_sample),
      .drop_count   (drop_count),
      .out_valid    (out_valid),
      .out_word     (out_word),
      .seq_error    (seq_error),
      .balanced     (balanced),
      .checks_done  (checks_done),
      .value_errors (value_errors),
      .other_errors (other_errors)
   );

   //##########################################################################
   // stimulus
   //##########################################################################

   initial begin
      logic [31:0] bits;
      int          gap;
      rd_nreset   = 1'b0;
      in_valid    = 1'b0;
      in_sample   = '0;
      burst_phase = 1'b0;
      end_of_run  = 1'b0;
      lfsr_q      = 32'hdf2d;

      repeat (4) @(posedge rd_clk);
      #5 rd_nreset = 1'b1;
      repeat (10) @(posedge rd_clk);              // idle, outputs must stay low

      // sparse, one sample per 4 to 7 wr_clk cycles
      for (int n = 0; n < SPARSE_N; n++) begin
         @(posedge wr_clk);
         #5;
         draw_bits(16, bits);
         in_sample = bits[15:0];
         in_valid  = 1'b1;
         @(posedge wr_clk);
         #5 in_valid = 1'b0;
         draw_bits(2, bits);
         gap = int'(bits[1:0]);
         repeat (gap + 2) @(posedge wr_clk);
      end
      wait (balanced);                            // all sparse samples out

      // burst, overruns the fifo on purpose
      @(posedge wr_clk);
      #5 burst_phase = 1'b1;
      for (int n = 0; n < BURST_N; n++) begin
         draw_bits(16, bits);
         in_sample = bits[15:0];
         in_valid  = 1'b1;
         @(posedge wr_clk);
         #5;
      end
      in_valid = 1'b0;

      repeat (3) @(posedge wr_clk);               // last drop registered
      wait (balanced);
      repeat (20) @(posedge rd_clk);              // catch stray outputs
      #5 end_of_run = 1'b1;
      wait (checks_done);
      #1;

      print_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the stream did not drain within %0d ns", WATCHDOG_NS);
      print_counts();
      $display("Regression failed");
      $finish;
   end

endmodule

/* stream_cdc_top.f */
+incdir+src
src/cdc_pkg.sv
src/rst_sync.sv
src/gray_sync.sv
src/dual_port_ram.sv
src/async_fifo.sv
src/sample_framer.sv
src/stream_unpacker.sv
src/stream_cdc_top.sv
testbench/stream_checker.sv
testbench/tb_stream_cdc.sv

/* run.sh */
#!/bin/sh
# build the stream cdc testbench with verilator and run it
# pass or fail comes from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
   -f stream_cdc_top.f \
   --top-module tb_stream_cdc \
   -o sim_stream_cdc

./obj_dir/sim_stream_cdc > sim.log 2>&1
cat sim.log

if grep -q "^Regression passed$" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
